//--- Makefile
# Verilator flow for the GPS haversine project

VERILATOR ?= verilator
FILELIST  ?= gps_haversine.f
TB_TOP    ?= tb_gps_haversine
RTL_TOP   ?= gps_haversine_top
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# the run passes only if the pass message shows up in the output
sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q -F "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/cos_interp.sv
`timescale 1ns/1ps
`default_nettype none

module cos_interp
	import geo_pkg::*;
	import cos_table_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  lookup_start,
	input  coord_t                lookup_lat,
	input  logic [cos_data_w-1:0] cos_data,
	output cos_addr_t             cos_addr,
	output logic                  lookup_done,
	output frac64_t               cos_lat
);

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_search = 3'd1;
	localparam logic [2:0] st_below = 3'd2;
	localparam logic [2:0] st_prep = 3'd3;
	localparam logic [2:0] st_div = 3'd4;

	logic [2:0] state;

	logic [cos_field_w-1:0] x_in;
	logic [cos_field_w-1:0] y_in;
	logic [cos_field_w-1:0] lat_ext;
	logic [cos_field_w-1:0] x1;
	logic [cos_field_w-1:0] y1;
	logic [cos_field_w-1:0] y0;
	logic [cos_field_w-1:0] span;
	logic [cos_field_w-1:0] dlat;
	logic [cos_field_w-1:0] dy;
	logic [2*cos_field_w-1:0] numer;
	logic [127:0] dividend;
	logic x_hit;
	logic div_start;
	logic div_done;
	frac64_t quotient;

	assign x_in = cos_data[cos_data_w-1 -: cos_field_w];
	assign y_in = cos_data[cos_field_w-1:0];
	assign x_hit = x_in > lat_ext;

	// y0*(x1-x0) - (lat-x0)*(y0-y1), 32.64
	assign numer = y0 * span - dlat * dy;

	fixed_divider #(
		.dividend_w(128),
		.divisor_w(64)
	) fixed_divider_inst (
		.clk(clk),
		.reset_n(reset_n),
		.div_start(div_start),
		.dividend(dividend),
		.divisor(64'(span)),
		.div_done(div_done),
		.quotient(quotient)
	);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= st_idle;
			cos_addr <= cos_first_addr;
			div_start <= 1'b0;
			lookup_done <= 1'b0;
		end else begin
			div_start <= 1'b0;
			lookup_done <= 1'b0;
			case (state)
				st_idle: begin
					if (lookup_start)
						state <= st_search;
				end
				st_search: begin
					// step back to the entry below the first x above lat
					if (x_hit) begin
						cos_addr <= cos_addr - 1'b1;
						state <= st_below;
					end else begin
						cos_addr <= cos_addr + 1'b1;
					end
				end
				st_below: state <= st_prep;
				st_prep: begin
					div_start <= 1'b1;
					state <= st_div;
				end
				st_div: begin
					if (div_done) begin
						lookup_done <= 1'b1;
						cos_addr <= cos_first_addr;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		// latitude as 16.32
		if (state == st_idle && lookup_start)
			lat_ext <= cos_field_w'({lookup_lat, 16'd0});
		if (state == st_search && x_hit) begin
			x1 <= x_in;
			y1 <= y_in;
		end
		if (state == st_below) begin
			y0 <= y_in;
			span <= x1 - x_in;
			dlat <= lat_ext - x_in;
			dy <= y_in - y1;
		end
		// scale by 2^32 so the quotient is 0.64
		if (state == st_prep)
			dividend <= {numer, 32'd0};
		if (state == st_div && div_done)
			cos_lat <= quotient;
	end

	// table x must cover every latitude searched
	assert property (@(posedge clk) disable iff (!reset_n)
		(state == st_search && !x_hit) |-> cos_addr != cos_last_addr);

endmodule

`default_nettype wire

//--- design/cos_table_pkg.sv
`default_nettype none

package cos_table_pkg;

	localparam int cos_addr_w = 7;

	typedef logic [cos_addr_w-1:0] cos_addr_t;

	// search range of the table
	localparam cos_addr_t cos_first_addr = 7'd1;
	localparam cos_addr_t cos_last_addr = 7'd127;

	// x and y fields are both 16.32
	localparam int cos_field_w = 48;

	// x (degrees) in the upper half, y (cosine) in the lower half
	localparam int cos_data_w = 2 * cos_field_w;

endpackage

`default_nettype wire

//--- design/fixed_divider.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_divider #(
	parameter int dividend_w = 128,
	parameter int divisor_w = 64
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  div_start,
	input  logic [dividend_w-1:0] dividend,
	input  logic [divisor_w-1:0]  divisor,
	output logic                  div_done,
	output logic [63:0]           quotient
);

	logic                          running;
	logic [$clog2(dividend_w+1)-1:0] count;

	// partial remainder and dividend/quotient shift register
	logic [divisor_w-1:0]  rem;
	logic [dividend_w-1:0] sr;

	logic [divisor_w-1:0]  rem_in;
	logic [dividend_w-1:0] sr_in;
	logic [divisor_w:0]    shifted;
	logic [divisor_w:0]    diff;
	logic                  fits;

	// first step is taken in the same cycle as div_start
	assign rem_in = div_start ? '0 : rem;
	assign sr_in = div_start ? dividend : sr;

	assign shifted = {rem_in, sr_in[dividend_w-1]};
	assign diff = shifted - {1'b0, divisor};
	assign fits = shifted >= {1'b0, divisor};

	// quotient bits have replaced the dividend once done
	assign quotient = sr[63:0];

	always_ff @(posedge clk) begin
		if (div_start || running) begin
			rem <= fits ? diff[divisor_w-1:0] : shifted[divisor_w-1:0];
			sr <= {sr_in[dividend_w-2:0], fits};
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			running <= 1'b0;
			count <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= 1'b0;
			if (div_start) begin
				running <= 1'b1;
				count <= ($bits(count))'(dividend_w - 1);
			end else if (running) begin
				count <= count - 1'b1;
				// last quotient bit
				if (count == ($bits(count))'(1)) begin
					running <= 1'b0;
					div_done <= 1'b1;
				end
			end
		end
	end

	// the caller waits for div_done before the next division
	assert property (@(posedge clk) disable iff (!reset_n) div_start |-> !running);

endmodule

`default_nettype wire

//--- design/geo_pkg.sv
`default_nettype none

package geo_pkg;

	// one coordinate in degrees, 8 integer and 16 fraction bits
	localparam int coord_w = 24;

	typedef logic [coord_w-1:0] coord_t;

	// unsigned 0.64 fraction
	// used for cosines, squared half angles and the haversine term
	typedef logic [63:0] frac64_t;

	// pi/180 as a 0.16 fraction
	localparam logic [15:0] rad_per_deg = 16'h0477;

	// half angle in radians, 0.32
	localparam int angle_w = 32;

endpackage

`default_nettype wire

//--- design/gps_haversine_top.sv
`timescale 1ns/1ps
`default_nettype none

module gps_haversine_top
	import geo_pkg::*;
	import cos_table_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  den,
	input  coord_t                lon_in,
	input  coord_t                lat_in,
	input  logic [cos_data_w-1:0] cos_data,
	output cos_addr_t             cos_addr,
	output logic                  busy,
	output logic                  valid,
	output frac64_t               a
);

	logic    lookup_start;
	coord_t  lookup_lat;
	logic    lookup_done;
	frac64_t cos_lat;
	logic    core_start;
	logic    core_done;
	coord_t  prev_lat;
	coord_t  prev_lon;
	coord_t  cur_lat;
	coord_t  cur_lon;
	frac64_t prev_cos;
	frac64_t cur_cos;

	point_sequencer point_sequencer_inst (
		.clk(clk),
		.reset_n(reset_n),
		.den(den),
		.lon_in(lon_in),
		.lat_in(lat_in),
		.lookup_done(lookup_done),
		.cos_lat(cos_lat),
		.core_done(core_done),
		.busy(busy),
		.lookup_start(lookup_start),
		.lookup_lat(lookup_lat),
		.core_start(core_start),
		.prev_lat(prev_lat),
		.prev_lon(prev_lon),
		.cur_lat(cur_lat),
		.cur_lon(cur_lon),
		.prev_cos(prev_cos),
		.cur_cos(cur_cos)
	);

	// cosine lookup against the external table
	cos_interp cos_interp_inst (
		.clk(clk),
		.reset_n(reset_n),
		.lookup_start(lookup_start),
		.lookup_lat(lookup_lat),
		.cos_data(cos_data),
		.cos_addr(cos_addr),
		.lookup_done(lookup_done),
		.cos_lat(cos_lat)
	);

	haversine_core haversine_core_inst (
		.clk(clk),
		.reset_n(reset_n),
		.core_start(core_start),
		.prev_lat(prev_lat),
		.prev_lon(prev_lon),
		.cur_lat(cur_lat),
		.cur_lon(cur_lon),
		.prev_cos(prev_cos),
		.cur_cos(cur_cos),
		.core_done(core_done),
		.valid(valid),
		.a(a)
	);

endmodule

`default_nettype wire

//--- design/haversine_core.sv
`timescale 1ns/1ps
`default_nettype none

module haversine_core
	import geo_pkg::*;
(
	input  logic    clk,
	input  logic    reset_n,
	input  logic    core_start,
	input  coord_t  prev_lat,
	input  coord_t  prev_lon,
	input  coord_t  cur_lat,
	input  coord_t  cur_lon,
	input  frac64_t prev_cos,
	input  frac64_t cur_cos,
	output logic    core_done,
	output logic    valid,
	output frac64_t a
);

	// one bit per step after the first
	logic [4:0] stage;

	coord_t dlat;
	coord_t dlon;
	logic [coord_w+$bits(rad_per_deg)-1:0] lat_rad;
	logic [coord_w+$bits(rad_per_deg)-1:0] lon_rad;
	logic [angle_w-1:0] half_lat;
	logic [angle_w-1:0] half_lon;
	frac64_t sq_lat;
	frac64_t sq_lon;
	logic [127:0] cos_prod;
	logic [127:0] lon_term;
	logic [127:0] a_sum;

	// 8.32 radians
	assign lat_rad = dlat * rad_per_deg;
	assign lon_rad = dlon * rad_per_deg;

	assign a_sum = lon_term + {sq_lat, 64'd0};
	assign core_done = valid;

	always_ff @(posedge clk) begin
		if (core_start) begin
			dlat <= (cur_lat > prev_lat) ? cur_lat - prev_lat : prev_lat - cur_lat;
			dlon <= (cur_lon > prev_lon) ? cur_lon - prev_lon : prev_lon - cur_lon;
		end
		// halve and keep the fraction, sine taken as the angle
		if (stage[0]) begin
			half_lat <= lat_rad[angle_w:1];
			half_lon <= lon_rad[angle_w:1];
		end
		if (stage[1]) begin
			sq_lat <= half_lat * half_lat;
			sq_lon <= half_lon * half_lon;
		end
		if (stage[2])
			cos_prod <= prev_cos * cur_cos;
		if (stage[3])
			lon_term <= cos_prod[127:64] * sq_lon;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			stage <= '0;
			valid <= 1'b0;
			a <= '0;
		end else begin
			stage <= {stage[3:0], core_start};
			valid <= stage[4];
			if (stage[4])
				a <= a_sum[127:64];
		end
	end

	// starts are spaced by a full lookup, so results never back up
	assert property (@(posedge clk) disable iff (!reset_n) valid |=> !valid);

endmodule

`default_nettype wire

//--- design/point_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module point_sequencer
	import geo_pkg::*;
(
	input  logic    clk,
	input  logic    reset_n,
	input  logic    den,
	input  coord_t  lon_in,
	input  coord_t  lat_in,
	input  logic    lookup_done,
	input  frac64_t cos_lat,
	input  logic    core_done,
	output logic    busy,
	output logic    lookup_start,
	output coord_t  lookup_lat,
	output logic    core_start,
	output coord_t  prev_lat,
	output coord_t  prev_lon,
	output coord_t  cur_lat,
	output coord_t  cur_lon,
	output frac64_t prev_cos,
	output frac64_t cur_cos
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_lookup = 2'd1;
	localparam logic [1:0] st_core = 2'd2;

	logic [1:0] state;
	logic have_prev;
	logic accept;
	logic first_done;
	logic pair_done;
	logic lookup_pending;

	assign accept = state == st_idle && den;
	assign first_done = state == st_lookup && lookup_done && !have_prev;
	assign pair_done = state == st_core && core_done;

	assign lookup_lat = cur_lat;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= st_idle;
			have_prev <= 1'b0;
			busy <= 1'b0;
			lookup_start <= 1'b0;
			core_start <= 1'b0;
		end else begin
			lookup_start <= 1'b0;
			core_start <= 1'b0;
			case (state)
				st_idle: begin
					if (den) begin
						busy <= 1'b1;
						lookup_start <= 1'b1;
						state <= st_lookup;
					end
				end
				st_lookup: begin
					if (lookup_done) begin
						if (have_prev) begin
							core_start <= 1'b1;
							state <= st_core;
						end else begin
							// first point only fills the previous slot
							have_prev <= 1'b1;
							busy <= 1'b0;
							state <= st_idle;
						end
					end
				end
				st_core: begin
					if (core_done) begin
						busy <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cur_lat <= lat_in;
			cur_lon <= lon_in;
		end
		if (state == st_lookup && lookup_done)
			cur_cos <= cos_lat;
		// current point and its cosine move to the previous slot
		if (first_done || pair_done) begin
			prev_lat <= cur_lat;
			prev_lon <= cur_lon;
			prev_cos <= first_done ? cos_lat : cur_cos;
		end
	end

	// open from lookup_start until lookup_done
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			lookup_pending <= 1'b0;
		else if (lookup_start)
			lookup_pending <= 1'b1;
		else if (lookup_done)
			lookup_pending <= 1'b0;
	end

	// one lookup at a time
	assert property (@(posedge clk) disable iff (!reset_n)
		lookup_start |-> !lookup_pending);

endmodule

`default_nettype wire

//--- gps_haversine.f
+incdir+sim
design/geo_pkg.sv
design/cos_table_pkg.sv
design/fixed_divider.sv
design/cos_interp.sv
design/point_sequencer.sv
design/haversine_core.sv
design/gps_haversine_top.sv
sim/tb_gps_haversine.sv

//--- sim/haversine_ref.svh
`ifndef haversine_ref_svh
`define haversine_ref_svh

// table x field, i degrees as 16.32
function automatic logic [47:0] degree_field(input int i);
	return {16'(i), 32'd0};
endfunction

// table y field, cosine of i degrees as 16.32
// clamped to zero past 90 degrees so y never rises
function automatic logic [47:0] cosine_field(input int i);
	real r;
	if (i >= 90)
		return 48'd0;
	r = $cos(real'(i) * 3.14159265358979 / 180.0) * 4294967296.0;
	return 48'(longint'(r));
endfunction

// linear interpolation between the entries around lat
function automatic frac64_t interp_cos(input coord_t lat);
	logic [47:0] lat_ext;
	logic [47:0] x0;
	logic [47:0] x1;
	logic [47:0] y0;
	logic [47:0] y1;
	logic [95:0] numer;
	logic [127:0] q;
	int i;
	lat_ext = {8'd0, lat, 16'd0};
	i = 1;
	while (i < 127 && degree_field(i) <= lat_ext)
		i = i + 1;
	x1 = degree_field(i);
	y1 = cosine_field(i);
	x0 = degree_field(i - 1);
	y0 = cosine_field(i - 1);
	numer = 96'(y0) * 96'(x1 - x0) - 96'(lat_ext - x0) * 96'(y0 - y1);
	q = {numer, 32'd0} / {80'd0, x1 - x0};
	return q[63:0];
endfunction

// haversine term of two points, small angle sine
function automatic frac64_t haversine_term(
	input coord_t lat_a, input coord_t lon_a, input frac64_t cos_a,
	input coord_t lat_b, input coord_t lon_b, input frac64_t cos_b
);
	coord_t dlat;
	coord_t dlon;
	logic [31:0] half_lat;
	logic [31:0] half_lon;
	frac64_t sq_lat;
	frac64_t sq_lon;
	logic [127:0] cos_prod;
	logic [127:0] total;
	dlat = (lat_a > lat_b) ? lat_a - lat_b : lat_b - lat_a;
	dlon = (lon_a > lon_b) ? lon_a - lon_b : lon_b - lon_a;
	// 8.32 radians halved, fraction kept
	half_lat = 32'((40'(dlat) * 40'(rad_per_deg)) >> 1);
	half_lon = 32'((40'(dlon) * 40'(rad_per_deg)) >> 1);
	sq_lat = 64'(half_lat) * 64'(half_lat);
	sq_lon = 64'(half_lon) * 64'(half_lon);
	cos_prod = 128'(cos_a) * 128'(cos_b);
	total = 128'(cos_prod[127:64]) * 128'(sq_lon) + {sq_lat, 64'd0};
	return total[127:64];
endfunction

`endif

//--- sim/tb_gps_haversine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gps_haversine
	import geo_pkg::*;
	import cos_table_pkg::*;
();

	`include "haversine_ref.svh"

	localparam int random_points = 12;
	localparam int timeout_cycles = 1000;
	localparam int quiet_cycles = 300;

	logic clk = 1'b0;
	logic reset_n;
	logic den;
	coord_t lon_in;
	coord_t lat_in;
	logic [cos_data_w-1:0] cos_data;
	cos_addr_t cos_addr;
	logic busy;
	logic valid;
	frac64_t a;

	logic [cos_data_w-1:0] table_mem [0:127];
	int seed;
	int errors = 0;
	int checks = 0;
	int valid_count = 0;
	logic have_prev;
	coord_t model_lat;
	coord_t model_lon;

	gps_haversine_top gps_haversine_top_inst (
		.clk(clk),
		.reset_n(reset_n),
		.den(den),
		.lon_in(lon_in),
		.lat_in(lat_in),
		.cos_data(cos_data),
		.cos_addr(cos_addr),
		.busy(busy),
		.valid(valid),
		.a(a)
	);

	always #5 clk = ~clk;

	// external cosine table read combinationally
	assign cos_data = table_mem[cos_addr];

	always @(negedge clk) begin
		if (valid === 1'b1)
			valid_count = valid_count + 1;
	end

	task automatic report_and_finish();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks = checks + 1;
		if (actual !== expected) begin
			errors = errors + 1;
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic wait_not_busy(input string name);
		int cycles;
		cycles = 0;
		while (busy !== 1'b0 && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (busy !== 1'b0) begin
			errors = errors + 1;
			$display("timeout in %s: busy never went low", name);
			report_and_finish();
		end
	endtask

	function automatic coord_t random_coord(input int lo_deg, input int hi_deg);
		int span;
		span = (hi_deg - lo_deg) * 65536;
		return coord_t'(lo_deg * 65536 + int'($unsigned($random(seed)) % $unsigned(span)));
	endfunction

	// move by less than 4 degrees and reflect at the range edges
	function automatic coord_t step_coord(input coord_t from, input int lo_deg,
		input int hi_deg);
		int delta;
		int moved;
		delta = int'($unsigned($random(seed)) % 32'd524287) - 262143;
		moved = int'(from) + delta;
		if (moved < lo_deg * 65536 || moved > hi_deg * 65536)
			moved = int'(from) - delta;
		return coord_t'(moved);
	endfunction

	task automatic send_point(input coord_t lat, input coord_t lon);
		den = 1'b1;
		lat_in = lat;
		lon_in = lon;
		@(negedge clk);
		den = 1'b0;
	endtask

	// wait for the point to finish and compare against the model
	task automatic finish_point(input string name, input coord_t lat, input coord_t lon,
		input int count_before);
		wait_not_busy(name);
		@(negedge clk);
		check_value({name, "_cos_addr"}, 64'(cos_first_addr), 64'(cos_addr));
		if (have_prev) begin
			check_value({name, "_valid_count"}, 64'd1, 64'(valid_count - count_before));
			check_value(name, haversine_term(model_lat, model_lon, interp_cos(model_lat),
				lat, lon, interp_cos(lat)), a);
		end else begin
			check_value({name, "_no_valid"}, 64'd0, 64'(valid_count - count_before));
		end
		have_prev = 1'b1;
		model_lat = lat;
		model_lon = lon;
	endtask

	task automatic run_point(input string name, input coord_t lat, input coord_t lon);
		int count_before;
		count_before = valid_count;
		send_point(lat, lon);
		check_value({name, "_busy"}, 64'd1, 64'(busy));
		finish_point(name, lat, lon, count_before);
	endtask

	task automatic apply_reset();
		reset_n = 1'b0;
		repeat (4) @(negedge clk);
		check_value("reset_busy", 64'd0, 64'(busy));
		check_value("reset_valid", 64'd0, 64'(valid));
		check_value("reset_a", 64'd0, a);
		check_value("reset_cos_addr", 64'(cos_first_addr), 64'(cos_addr));
		reset_n = 1'b1;
		have_prev = 1'b0;
	endtask

	initial begin
		coord_t lat;
		coord_t lon;
		coord_t skip_lat;
		int count_before;
		seed = 44;
		reset_n = 1'b0;
		den = 1'b0;
		lat_in = '0;
		lon_in = '0;
		for (int k = 0; k < 128; k++)
			table_mem[k] = {degree_field(k), cosine_field(k)};
		apply_reset();

		// first point fills the previous slot only
		lat = random_coord(1, 60);
		lon = random_coord(10, 200);
		run_point("first_point", lat, lon);

		for (int n = 0; n < random_points; n++) begin
			lat = step_coord(model_lat, 1, 60);
			lon = step_coord(model_lon, 10, 200);
			run_point("random_pair", lat, lon);
		end

		run_point("same_point", model_lat, model_lon);
		check_value("same_point_zero", 64'd0, a);

		// den during busy must be dropped
		lat = step_coord(model_lat, 1, 60);
		lon = step_coord(model_lon, 10, 200);
		skip_lat = step_coord(lat, 1, 60);
		count_before = valid_count;
		send_point(lat, lon);
		repeat (3) @(negedge clk);
		check_value("skip_busy", 64'd1, 64'(busy));
		send_point(skip_lat, lon);
		finish_point("skip_pair", lat, lon, count_before);
		lat = step_coord(model_lat, 1, 60);
		lon = step_coord(model_lon, 10, 200);
		run_point("after_skip", lat, lon);

		// reset in the middle of a lookup
		lat = step_coord(model_lat, 1, 60);
		lon = step_coord(model_lon, 10, 200);
		send_point(lat, lon);
		repeat (40) @(negedge clk);
		check_value("busy_before_reset", 64'd1, 64'(busy));
		count_before = valid_count;
		apply_reset();
		// longer than a full lookup and core, so the aborted point cannot finish late
		repeat (quiet_cycles) @(negedge clk);
		check_value("reset_no_valid", 64'(count_before), 64'(valid_count));
		check_value("reset_idle_busy", 64'd0, 64'(busy));
		lat = random_coord(1, 60);
		lon = random_coord(10, 200);
		run_point("after_reset_first", lat, lon);
		lat = step_coord(model_lat, 1, 60);
		lon = step_coord(model_lon, 10, 200);
		run_point("after_reset_pair", lat, lon);

		report_and_finish();
	end

endmodule

`default_nettype wire
